//--- source/exu_cfg_pkg.sv
// ----------------------------------------------------------------------
// execute unit configuration
// data, register index and commit tag widths, writeback credit pool
// size and multiplier depth, with the vector types built on them
// ----------------------------------------------------------------------

package exu_cfg_pkg;

    localparam int unsigned XLEN        = 32;
    localparam int unsigned REG_ADDR_W  = 5;
    localparam int unsigned COMMIT_ID_W = 4;

    // credits granted by writeback at reset
    localparam int unsigned WB_CREDITS  = 4;
    localparam int unsigned CREDIT_W    = $clog2(WB_CREDITS + 1);

    // multiplier stages, issue to writeback
    localparam int unsigned MUL_LATENCY = 3;

    typedef logic [XLEN-1:0]        data_t;
    typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [COMMIT_ID_W-1:0] commit_id_t;
    typedef logic [CREDIT_W-1:0]    credit_cnt_t;

endpackage

//--- source/exu_op_pkg.sv
// ----------------------------------------------------------------------
// execute unit operation types
// operation and unit codes plus the issue, micro-op and writeback
// records passed between dispatch, decode, execute and writeback
// ----------------------------------------------------------------------

package exu_op_pkg;

    import exu_cfg_pkg::*;

    typedef enum logic [4:0] {
        // alu
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
        // multiplier
        OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
        // branch unit
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_JAL, OP_JALR
    } exu_op_e;

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_MUL,
        UNIT_BRU
    } exu_unit_e;

    // operation as offered by dispatch
    typedef struct packed {
        exu_op_e    op;
        data_t      op1;
        data_t      op2;
        data_t      imm;
        data_t      pc;
        reg_addr_t  rd;
        commit_id_t commit_id;
    } exu_issue_t;

    // decoded operation
    typedef struct packed {
        exu_unit_e  unit;
        exu_op_e    op;
        data_t      op1;
        data_t      op2;
        data_t      pc;
        data_t      imm;
        reg_addr_t  rd;
        commit_id_t commit_id;
        logic       writes_rd;
    } exu_uop_t;

    typedef struct packed {
        data_t      data;
        reg_addr_t  rd;
        commit_id_t commit_id;
    } exu_wb_t;

endpackage

//--- source/exu_decode.sv
// ----------------------------------------------------------------------
// execute decode
// maps an issued operation onto its execution unit and works out
// whether it writes a destination register
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module exu_decode
    import exu_cfg_pkg::*;
    import exu_op_pkg::*;
(
    input  exu_issue_t issue_i,
    output exu_uop_t   uop_o
);

    exu_unit_e unit;
    logic      link;

    always_comb begin
        case (issue_i.op)
            OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU: begin
                unit = UNIT_MUL;
            end
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
            OP_JAL, OP_JALR: begin
                unit = UNIT_BRU;
            end
            default: begin
                unit = UNIT_ALU;
            end
        endcase
    end

    // jumps write the link address, conditional branches write nothing
    assign link = (issue_i.op == OP_JAL) || (issue_i.op == OP_JALR);

    always_comb begin
        uop_o.unit      = unit;
        uop_o.op        = issue_i.op;
        uop_o.op1       = issue_i.op1;
        uop_o.op2       = issue_i.op2;
        uop_o.pc        = issue_i.pc;
        uop_o.imm       = issue_i.imm;
        uop_o.rd        = issue_i.rd;
        uop_o.commit_id = issue_i.commit_id;
        // x0 writes are dropped here so they never take a credit
        uop_o.writes_rd = ((unit != UNIT_BRU) || link)
                          && (issue_i.rd != reg_addr_t'(0));
    end

endmodule

//--- source/exu_execute.sv
// ----------------------------------------------------------------------
// execute datapath
// one-cycle ALU with link path, pipelined multiplier, branch compare
// and target, and the issue stall for credits and writeback collisions
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module exu_execute
    import exu_cfg_pkg::*;
    import exu_op_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     issue_valid_i,
    input  exu_uop_t uop_i,
    input  logic     credit_ok_i,
    output logic     issue_stall_o,
    output logic     reserve_o,
    output logic     alu_valid_o,
    output exu_wb_t  alu_wb_o,
    output logic     mul_valid_o,
    output exu_wb_t  mul_wb_o,
    output logic     jump_valid_o,
    output data_t    jump_target_o
);

    typedef struct packed {
        logic                  wr;
        logic                  hi;
        reg_addr_t             rd;
        commit_id_t            commit_id;
        logic [2*XLEN-1:0]     prod;
    } mul_stage_t;

    logic                    accept;
    logic                    collision;
    data_t                   alu_res;
    logic                    taken;
    data_t                   jalr_sum;
    logic                    sign_a;
    logic                    sign_b;
    logic signed [XLEN:0]    mul_a;
    logic signed [XLEN:0]    mul_b;
    logic signed [2*XLEN+1:0] mul_full;
    logic                    alu_vld_q;
    exu_wb_t                 alu_wb_q;
    logic [MUL_LATENCY-1:0]  mul_vld_q;
    mul_stage_t              mul_q [MUL_LATENCY];

    // a multiply that is MUL_LATENCY-1 cycles old lands together with
    // any ALU or link result accepted now
    assign collision     = mul_vld_q[MUL_LATENCY-2] && (uop_i.unit != UNIT_MUL);
    assign issue_stall_o = issue_valid_i
                           && ((uop_i.writes_rd && !credit_ok_i) || collision);
    assign accept        = issue_valid_i && !issue_stall_o;
    assign reserve_o     = accept && uop_i.writes_rd;

    always_comb begin
        case (uop_i.op)
            OP_SUB:  alu_res = uop_i.op1 - uop_i.op2;
            OP_AND:  alu_res = uop_i.op1 & uop_i.op2;
            OP_OR:   alu_res = uop_i.op1 | uop_i.op2;
            OP_XOR:  alu_res = uop_i.op1 ^ uop_i.op2;
            OP_SLL:  alu_res = uop_i.op1 << uop_i.op2[4:0];
            OP_SRL:  alu_res = uop_i.op1 >> uop_i.op2[4:0];
            OP_SRA:  alu_res = data_t'($signed(uop_i.op1) >>> uop_i.op2[4:0]);
            OP_SLT:  alu_res = data_t'($signed(uop_i.op1) < $signed(uop_i.op2));
            OP_SLTU: alu_res = data_t'(uop_i.op1 < uop_i.op2);
            // add, and a don't-care for the other units
            default: alu_res = uop_i.op1 + uop_i.op2;
        endcase
    end

    always_comb begin
        case (uop_i.op)
            OP_BEQ:          taken = (uop_i.op1 == uop_i.op2);
            OP_BNE:          taken = (uop_i.op1 != uop_i.op2);
            OP_BLT:          taken = ($signed(uop_i.op1) < $signed(uop_i.op2));
            OP_BGE:          taken = ($signed(uop_i.op1) >= $signed(uop_i.op2));
            OP_BLTU:         taken = (uop_i.op1 < uop_i.op2);
            OP_BGEU:         taken = (uop_i.op1 >= uop_i.op2);
            OP_JAL, OP_JALR: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    assign jalr_sum      = uop_i.op1 + uop_i.imm;
    assign jump_valid_o  = accept && (uop_i.unit == UNIT_BRU) && taken;
    assign jump_target_o = (uop_i.op == OP_JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
                                                 : uop_i.pc + uop_i.imm;

    // alu and link results, one cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            alu_vld_q <= 1'b0;
        end else begin
            alu_vld_q <= reserve_o && (uop_i.unit != UNIT_MUL);
        end
    end

    always_ff @(posedge clk) begin
        alu_wb_q.data      <= (uop_i.unit == UNIT_BRU) ? uop_i.pc + data_t'(4) : alu_res;
        alu_wb_q.rd        <= uop_i.rd;
        alu_wb_q.commit_id <= uop_i.commit_id;
    end

    assign alu_valid_o = alu_vld_q;
    assign alu_wb_o    = alu_wb_q;

    // 33x33 signed product covers all four multiply flavours
    assign sign_a   = (uop_i.op == OP_MULH) || (uop_i.op == OP_MULHSU);
    assign sign_b   = (uop_i.op == OP_MULH);
    assign mul_a    = {sign_a & uop_i.op1[XLEN-1], uop_i.op1};
    assign mul_b    = {sign_b & uop_i.op2[XLEN-1], uop_i.op2};
    assign mul_full = mul_a * mul_b;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mul_vld_q <= '0;
        end else begin
            mul_vld_q <= {mul_vld_q[MUL_LATENCY-2:0],
                          accept && (uop_i.unit == UNIT_MUL)};
        end
    end

    always_ff @(posedge clk) begin
        mul_q[0].wr        <= uop_i.writes_rd;
        mul_q[0].hi        <= (uop_i.op != OP_MUL);
        mul_q[0].rd        <= uop_i.rd;
        mul_q[0].commit_id <= uop_i.commit_id;
        mul_q[0].prod      <= mul_full[2*XLEN-1:0];
        for (int i = 1; i < MUL_LATENCY; i++) begin
            mul_q[i] <= mul_q[i-1];
        end
    end

    assign mul_valid_o        = mul_vld_q[MUL_LATENCY-1] && mul_q[MUL_LATENCY-1].wr;
    assign mul_wb_o.data      = mul_q[MUL_LATENCY-1].hi ? mul_q[MUL_LATENCY-1].prod[2*XLEN-1:XLEN]
                                                        : mul_q[MUL_LATENCY-1].prod[XLEN-1:0];
    assign mul_wb_o.rd        = mul_q[MUL_LATENCY-1].rd;
    assign mul_wb_o.commit_id = mul_q[MUL_LATENCY-1].commit_id;

endmodule

//--- source/exu_result.sv
// ----------------------------------------------------------------------
// execute result stage
// writeback credit counter, single-port writeback merge and the
// registered jump request toward fetch
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module exu_result
    import exu_cfg_pkg::*;
    import exu_op_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    reserve_i,
    input  logic    credit_return_i,
    input  logic    alu_valid_i,
    input  exu_wb_t alu_wb_i,
    input  logic    mul_valid_i,
    input  exu_wb_t mul_wb_i,
    input  logic    jump_valid_i,
    input  data_t   jump_target_i,
    output logic    credit_ok_o,
    output logic    wb_valid_o,
    output exu_wb_t wb_o,
    output logic    jump_flag_o,
    output data_t   jump_addr_o
);

    credit_cnt_t credit_q;
    logic        jump_flag_q;
    data_t       jump_addr_q;

    // reserve and return in the same cycle leave the count alone
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            credit_q <= credit_cnt_t'(WB_CREDITS);
        end else if (reserve_i && !credit_return_i) begin
            credit_q <= credit_q - credit_cnt_t'(1);
        end else if (credit_return_i && !reserve_i) begin
            credit_q <= credit_q + credit_cnt_t'(1);
        end
    end

    assign credit_ok_o = (credit_q != credit_cnt_t'(0));

    // execute never lets both sources fire together
    assign wb_valid_o = alu_valid_i || mul_valid_i;
    assign wb_o       = mul_valid_i ? mul_wb_i : alu_wb_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            jump_flag_q <= 1'b0;
        end else begin
            jump_flag_q <= jump_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (jump_valid_i) begin
            jump_addr_q <= jump_target_i;
        end
    end

    assign jump_flag_o = jump_flag_q;
    assign jump_addr_o = jump_addr_q;

endmodule

//--- source/exu_core.sv
// ----------------------------------------------------------------------
// integer execute unit, single issue
// decode, ALU/multiplier/branch execution and a credit-controlled
// writeback port tagged with rd and commit id
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module exu_core
    import exu_cfg_pkg::*;
    import exu_op_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       issue_valid_i,
    input  exu_issue_t issue_i,
    output logic       issue_stall_o,
    input  logic       credit_return_i,
    output logic       wb_valid_o,
    output exu_wb_t    wb_o,
    output logic       jump_flag_o,
    output data_t      jump_addr_o
);

    exu_uop_t uop;
    logic     credit_ok;
    logic     reserve;
    logic     alu_valid;
    exu_wb_t  alu_wb;
    logic     mul_valid;
    exu_wb_t  mul_wb;
    logic     jump_valid;
    data_t    jump_target;

    exu_decode i_decode (
        .issue_i (issue_i),
        .uop_o   (uop)
    );

    exu_execute i_execute (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .uop_i         (uop),
        .credit_ok_i   (credit_ok),
        .issue_stall_o (issue_stall_o),
        .reserve_o     (reserve),
        .alu_valid_o   (alu_valid),
        .alu_wb_o      (alu_wb),
        .mul_valid_o   (mul_valid),
        .mul_wb_o      (mul_wb),
        .jump_valid_o  (jump_valid),
        .jump_target_o (jump_target)
    );

    exu_result i_result (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .reserve_i       (reserve),
        .credit_return_i (credit_return_i),
        .alu_valid_i     (alu_valid),
        .alu_wb_i        (alu_wb),
        .mul_valid_i     (mul_valid),
        .mul_wb_i        (mul_wb),
        .jump_valid_i    (jump_valid),
        .jump_target_i   (jump_target),
        .credit_ok_o     (credit_ok),
        .wb_valid_o      (wb_valid_o),
        .wb_o            (wb_o),
        .jump_flag_o     (jump_flag_o),
        .jump_addr_o     (jump_addr_o)
    );

endmodule

//--- tests/exu_core_checker.sv
// ----------------------------------------------------------------------
// execute unit protocol checker
// concurrent assertions on reset behavior, the writeback credit pool
// and the reasons for stalling a writing operation
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module exu_core_checker
    import exu_cfg_pkg::*;
    import exu_op_pkg::*;
(
    input logic     clk,
    input logic     rst_n_i,
    input logic     issue_valid_i,
    input logic     issue_stall_o,
    input logic     credit_return_i,
    input logic     wb_valid_o,
    input logic     credit_ok_i,
    input exu_uop_t uop_i
);

    logic in_rst_q;
    int   outstanding_q;
    logic mul_acc;

    assign mul_acc = issue_valid_i && !issue_stall_o && (uop_i.unit == UNIT_MUL);

    always_ff @(posedge clk) begin
        in_rst_q <= !rst_n_i;
    end

    // credits held by operations whose writeback has not been returned
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            outstanding_q <= 0;
        end else begin
            outstanding_q <= outstanding_q
                             + int'(issue_valid_i && !issue_stall_o && uop_i.writes_rd)
                             - int'(credit_return_i);
        end
    end

    wb_quiet_in_reset: assert property (@(posedge clk)
        (!rst_n_i && in_rst_q) |-> !wb_valid_o)
        else $error("writeback valid while reset is held");

    credits_bounded: assert property (@(posedge clk) disable iff (!rst_n_i)
        outstanding_q <= int'(WB_CREDITS))
        else $error("more writers outstanding than credits granted");

    stall_has_reason: assert property (@(posedge clk) disable iff (!rst_n_i)
        (issue_valid_i && issue_stall_o && uop_i.writes_rd)
        |-> (!credit_ok_i || ((uop_i.unit != UNIT_MUL) && $past(mul_acc, 2))))
        else $error("writing op stalled with credits free and no collision");

endmodule

bind exu_core exu_core_checker i_checker (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .issue_valid_i   (issue_valid_i),
    .issue_stall_o   (issue_stall_o),
    .credit_return_i (credit_return_i),
    .wb_valid_o      (wb_valid_o),
    .credit_ok_i     (credit_ok),
    .uop_i           (uop)
);

//--- tests/tb_exu_core.sv
// ----------------------------------------------------------------------
// execute unit testbench
// random ALU, multiply and branch traffic against a cycle-accurate
// reference model, with a credit-returning writeback environment
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module tb_exu_core
    import exu_cfg_pkg::*;
    import exu_op_pkg::*;
();

    localparam int N_ALU      = 60;
    localparam int N_MUL      = 40;
    localparam int N_BRU      = 60;
    localparam int N_CREDIT   = WB_CREDITS + 3;
    localparam int N_OPS      = N_ALU + N_MUL + N_BRU + N_CREDIT;
    localparam int TIMEOUT_CY = N_OPS * 10 + 200;

    logic       clk             = 1'b0;
    logic       rst_n_i;
    logic       issue_valid_i;
    exu_issue_t issue_i;
    logic       issue_stall_o;
    logic       credit_return_i = 1'b0;
    logic       wb_valid_o;
    exu_wb_t    wb_o;
    logic       jump_flag_o;
    data_t      jump_addr_o;

    int         seed = 32'h1c91401a;
    int         cyc  = 0;
    int         errors;
    int         checks;
    int         tests;
    int         failed_tests;
    int         test_err0;
    commit_id_t next_id;
    exu_wb_t    wb_due [int];
    data_t      jump_due [int];
    int         ret_q [$];
    bit         hold_credits = 1'b0;
    int         model_credits;
    logic [1:0] mul_hist;
    int         peak_inflight;

    exu_core i_dut (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .issue_valid_i   (issue_valid_i),
        .issue_i         (issue_i),
        .issue_stall_o   (issue_stall_o),
        .credit_return_i (credit_return_i),
        .wb_valid_o      (wb_valid_o),
        .wb_o            (wb_o),
        .jump_flag_o     (jump_flag_o),
        .jump_addr_o     (jump_addr_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic is_mul(input exu_op_e op);
        return op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
    endfunction

    function automatic logic is_cond(input exu_op_e op);
        return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    endfunction

    function automatic logic writes_rd(input exu_issue_t op);
        return (op.rd != reg_addr_t'(0)) && !is_cond(op.op);
    endfunction

    // sra through a sign-filled double word, slt through the sign bits
    function automatic data_t alu_model(input exu_op_e op, input data_t a, input data_t b);
        logic [2*XLEN-1:0] ext;
        data_t             r;
        ext = {{XLEN{a[XLEN-1]}}, a} >> b[4:0];
        case (op)
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLL:  r = a << b[4:0];
            OP_SRL:  r = a >> b[4:0];
            OP_SRA:  r = ext[XLEN-1:0];
            OP_SLT:  r = data_t'((a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : (a < b));
            OP_SLTU: r = data_t'(a < b);
            default: r = a + b;
        endcase
        return r;
    endfunction

    // 64-bit products of sign- or zero-extended operands
    function automatic data_t mul_model(input exu_op_e op, input data_t a, input data_t b);
        logic [2*XLEN-1:0] sa;
        logic [2*XLEN-1:0] sb;
        logic [2*XLEN-1:0] ua;
        logic [2*XLEN-1:0] ub;
        logic [2*XLEN-1:0] p;
        sa = {{XLEN{a[XLEN-1]}}, a};
        sb = {{XLEN{b[XLEN-1]}}, b};
        ua = {{XLEN{1'b0}}, a};
        ub = {{XLEN{1'b0}}, b};
        case (op)
            OP_MULH:   p = sa * sb;
            OP_MULHSU: p = sa * ub;
            default:   p = ua * ub;
        endcase
        return (op == OP_MUL) ? p[XLEN-1:0] : p[2*XLEN-1:XLEN];
    endfunction

    function automatic logic jump_taken(input exu_issue_t op);
        data_t sa;
        data_t sb;
        logic  t;
        // flipping the sign bit turns a signed compare into an unsigned one
        sa = op.op1 ^ 32'h8000_0000;
        sb = op.op2 ^ 32'h8000_0000;
        case (op.op)
            OP_BEQ:          t = (op.op1 == op.op2);
            OP_BNE:          t = (op.op1 != op.op2);
            OP_BLT:          t = (sa < sb);
            OP_BGE:          t = !(sa < sb);
            OP_BLTU:         t = (op.op1 < op.op2);
            OP_BGEU:         t = !(op.op1 < op.op2);
            OP_JAL, OP_JALR: t = 1'b1;
            default:         t = 1'b0;
        endcase
        return t;
    endfunction

    function automatic data_t jump_target(input exu_issue_t op);
        if (op.op == OP_JALR) begin
            return (op.op1 + op.imm) & ~data_t'(1);
        end
        return op.pc + op.imm;
    endfunction

    function automatic exu_issue_t random_op(input exu_op_e base, input int span);
        exu_issue_t op;
        data_t      r;
        op.op  = exu_op_e'(int'(base) + int'($unsigned($random(seed)) % span));
        op.op1 = $random(seed);
        op.op2 = $random(seed);
        // equal operands now and then so beq and bge see the equal case
        if ($unsigned($random(seed)) % 4 == 0) begin
            op.op2 = op.op1;
        end
        r             = $random(seed);
        op.imm        = {{(XLEN-12){r[11]}}, r[11:1], 1'b0};
        op.pc         = data_t'($random(seed)) & ~data_t'(3);
        op.rd         = reg_addr_t'($random(seed));
        op.commit_id  = '0;
        return op;
    endfunction

    task automatic report_error(input string what);
        errors++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    task automatic check_wb(input exu_wb_t exp, input exu_wb_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED t=%0t wb_o expected %h actual %h", $time, exp, act);
        end
    endtask

    task automatic check_jump(input data_t exp, input data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED t=%0t jump_addr_o expected %h actual %h", $time, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED t=%0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic compare_outputs();
        if (wb_due.exists(cyc)) begin
            if (wb_valid_o !== 1'b1) begin
                report_error("expected writeback did not arrive");
            end else begin
                check_wb(wb_due[cyc], wb_o);
            end
            wb_due.delete(cyc);
        end else if (wb_valid_o !== 1'b0) begin
            report_error("writeback appeared with no operation due");
        end
        // writeback stage hands the credit back 0 to 3 cycles later
        if (wb_valid_o === 1'b1) begin
            ret_q.push_back(cyc + int'($unsigned($random(seed)) % 4));
        end
        if (jump_due.exists(cyc)) begin
            if (jump_flag_o !== 1'b1) begin
                report_error("expected jump flag did not arrive");
            end else begin
                check_jump(jump_due[cyc], jump_addr_o);
            end
            jump_due.delete(cyc);
        end else if (jump_flag_o !== 1'b0) begin
            report_error("jump flag raised with no taken branch");
        end
    endtask

    task automatic model_issue();
        exu_issue_t op;
        logic       wr;
        logic       acc;
        logic       exp_stall;
        exu_wb_t    e;
        op        = issue_i;
        wr        = issue_valid_i && writes_rd(op);
        exp_stall = issue_valid_i
                    && ((wr && model_credits == 0) || (!is_mul(op.op) && mul_hist[1]));
        check_flag("issue_stall_o", exp_stall, issue_stall_o);
        acc = issue_valid_i && !issue_stall_o;
        if (acc && wr) begin
            if (is_mul(op.op)) begin
                e.data = mul_model(op.op, op.op1, op.op2);
            end else if (op.op == OP_JAL || op.op == OP_JALR) begin
                e.data = op.pc + data_t'(4);
            end else begin
                e.data = alu_model(op.op, op.op1, op.op2);
            end
            e.rd        = op.rd;
            e.commit_id = op.commit_id;
            wb_due[cyc + (is_mul(op.op) ? int'(MUL_LATENCY) : 1)] = e;
            if (wb_due.num() > peak_inflight) begin
                peak_inflight = wb_due.num();
            end
        end
        if (acc && jump_taken(op)) begin
            jump_due[cyc + 1] = jump_target(op);
        end
        model_credits = model_credits + int'(credit_return_i) - int'(acc && wr);
        mul_hist      = {mul_hist[0], acc && is_mul(op.op)};
    endtask

    always @(negedge clk) begin
        if (rst_n_i) begin
            compare_outputs();
            model_issue();
        end
    end

    // at most one credit pulse per cycle, oldest ready return first
    always @(posedge clk) begin
        int idx;
        #10;
        idx = -1;
        foreach (ret_q[i]) begin
            if (idx < 0 && ret_q[i] <= cyc) begin
                idx = i;
            end
        end
        credit_return_i = 1'b0;
        if (!hold_credits && idx >= 0) begin
            ret_q.delete(idx);
            credit_return_i = 1'b1;
        end
    end

    task automatic send_op(input exu_issue_t op, output int stalls);
        op.commit_id  = next_id;
        next_id       = next_id + commit_id_t'(1);
        issue_i       = op;
        issue_valid_i = 1'b1;
        stalls        = 0;
        @(negedge clk);
        while (issue_stall_o) begin
            stalls++;
            @(negedge clk);
        end
        @(posedge clk);
        #10;
        issue_valid_i = 1'b0;
    endtask

    // wait until every result is out and every credit is back
    task automatic settle();
        while (wb_due.num() != 0 || jump_due.num() != 0 || ret_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #10;
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors != test_err0) begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, errors - test_err0);
        end else begin
            $display("test %s: passed", name);
        end
        test_err0 = errors;
    endtask

    task automatic run_random(input exu_op_e base, input int span, input int count);
        exu_issue_t op;
        int         stalls;
        repeat (count) begin
            op = random_op(base, span);
            send_op(op, stalls);
        end
        settle();
    endtask

    initial begin
        #(TIMEOUT_CY * 100);
        $display("timeout: run did not complete within %0d cycles", TIMEOUT_CY);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        exu_issue_t op;
        int         stalls;
        rst_n_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        failed_tests  = 0;
        test_err0     = 0;
        next_id       = '0;
        model_credits = WB_CREDITS;
        mul_hist      = '0;
        peak_inflight = 0;
        repeat (5) @(posedge clk);
        #10;
        rst_n_i = 1'b1;

        repeat (4) begin
            @(negedge clk);
            check_flag("wb_valid_o", 1'b0, wb_valid_o);
            check_flag("jump_flag_o", 1'b0, jump_flag_o);
        end
        @(posedge clk);
        #10;
        finish_test("reset");

        run_random(OP_ADD, 10, N_ALU);
        finish_test("alu");

        peak_inflight = 0;
        run_random(OP_MUL, 4, N_MUL);
        if (peak_inflight < 2) begin
            report_error("multiplier never held more than one operation in flight");
        end
        finish_test("multiplier");

        run_random(OP_BEQ, 8, N_BRU);
        finish_test("branch");

        // exhaust the pool, then release credits under a stalled writer
        hold_credits = 1'b1;
        repeat (WB_CREDITS) begin
            op = random_op(OP_ADD, 10);
            op.rd = (op.rd == reg_addr_t'(0)) ? reg_addr_t'(1) : op.rd;
            send_op(op, stalls);
        end
        op = random_op(OP_ADD, 10);
        op.rd = (op.rd == reg_addr_t'(0)) ? reg_addr_t'(1) : op.rd;
        fork
            send_op(op, stalls);
            begin
                repeat (4) @(negedge clk);
                check_flag("issue_stall_o", 1'b1, issue_stall_o);
                hold_credits = 1'b0;
            end
        join
        settle();
        op = random_op(OP_MUL, 4);
        op.rd = (op.rd == reg_addr_t'(0)) ? reg_addr_t'(2) : op.rd;
        send_op(op, stalls);
        @(posedge clk);
        #10;
        op = random_op(OP_ADD, 10);
        send_op(op, stalls);
        if (stalls != 1) begin
            report_error("ALU op two cycles after a multiply was not held for one cycle");
        end
        settle();
        finish_test("credits");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- exu_core.f
source/exu_cfg_pkg.sv
source/exu_op_pkg.sv
source/exu_decode.sv
source/exu_execute.sv
source/exu_result.sv
source/exu_core.sv
tests/exu_core_checker.sv
tests/tb_exu_core.sv

//--- run_sim.sh
#!/bin/sh
# build the execute unit testbench with Verilator, run it and scan the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f exu_core.f \
    --top-module tb_exu_core -o tb_exu_core \
    && { ./obj_dir/tb_exu_core > sim.log 2>&1; grep -qx '\*\* PASS \*\*' sim.log; } \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
